/* rtl/arena_geom_pkg.sv */
`default_nettype none

package arena_geom_pkg;

  // Screen coordinate, wide enough for the full arena plus box offsets.
  typedef logic [9:0] coord_t;

  // Clamp limits for a fighter's reference position.
  localparam coord_t ARENA_MIN_X = 10'd50;
  localparam coord_t ARENA_MAX_X = 10'd490;

  // Positions after reset.
  localparam coord_t START_X_LEFT  = 10'd210;
  localparam coord_t START_X_RIGHT = 10'd420;

  // No vertical motion, so every fighter stands on the same line.
  localparam coord_t FLOOR_Y = 10'd170;

  // Sprite width, the mirror axis for a fighter that faces left.
  localparam coord_t SPRITE_W = 10'd150;

  // Hitbox offsets for a fighter that faces right.
  localparam coord_t HIT_NEAR = 10'd35;
  localparam coord_t HIT_FAR  = 10'd113;
  localparam coord_t HIT_TOP  = 10'd24;
  localparam coord_t HIT_BOT  = 10'd57;

  // Hurtbox offsets for a fighter that faces right.
  localparam coord_t HURT_NEAR   = 10'd37;
  localparam coord_t HURT_FAR    = 10'd86;
  localparam coord_t HURT_HEIGHT = 10'd150;

  // A fighter on the right side uses SPRITE_W - o for each horizontal
  // offset o, with near and far swapped so that x1 stays below x2.

endpackage

`default_nettype wire

/* rtl/fighter_pkg.sv */
`default_nettype none

package fighter_pkg;

  // Movement and attack states of one fighter.
  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,
    ST_FORWARD     = 3'd1,
    ST_BACKWARD    = 3'd2,
    ST_ATK_STARTUP = 3'd3,
    ST_ATK_ACTIVE  = 3'd4,
    ST_ATK_RECOVER = 3'd5
  } fighter_state_t;

  // Counts cycles inside one attack phase.
  typedef logic [4:0] phase_cnt_t;

  // Attack phase lengths in cycles.
  localparam int unsigned ATK_STARTUP_CYC = 6;
  localparam int unsigned ATK_ACTIVE_CYC  = 3;
  localparam int unsigned ATK_RECOVER_CYC = 17;

  // Pixels moved per cycle.
  localparam int unsigned STEP_FWD  = 3;
  localparam int unsigned STEP_BACK = 2;

  typedef logic [7:0] health_t;

  // Defaults for the top level health parameters.
  localparam int unsigned MAX_HEALTH = 100;
  localparam int unsigned HIT_DAMAGE = 10;

endpackage

`default_nettype wire

/* rtl/fighter.sv */
`timescale 1ns/10ps
`default_nettype none

module fighter #(
  parameter bit SIDE = 1'b0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        left,
  input  logic                        right,
  input  logic                        attack,
  input  logic                        ko,
  output arena_geom_pkg::coord_t      posx,
  output fighter_pkg::fighter_state_t state,
  output arena_geom_pkg::coord_t      hit_x1,
  output arena_geom_pkg::coord_t      hit_x2,
  output arena_geom_pkg::coord_t      hit_y1,
  output arena_geom_pkg::coord_t      hit_y2,
  output arena_geom_pkg::coord_t      hurt_x1,
  output arena_geom_pkg::coord_t      hurt_x2,
  output arena_geom_pkg::coord_t      hurt_y1,
  output arena_geom_pkg::coord_t      hurt_y2
);

  import arena_geom_pkg::*;
  import fighter_pkg::*;

  // Box offsets for this side, mirrored about the sprite when facing left.
  localparam coord_t HIT_X1_OFF  = (SIDE == 1'b0) ? HIT_NEAR : SPRITE_W - HIT_FAR;
  localparam coord_t HIT_X2_OFF  = (SIDE == 1'b0) ? HIT_FAR : SPRITE_W - HIT_NEAR;
  localparam coord_t HURT_X1_OFF = (SIDE == 1'b0) ? HURT_NEAR : SPRITE_W - HURT_FAR;
  localparam coord_t HURT_X2_OFF = (SIDE == 1'b0) ? HURT_FAR : SPRITE_W - HURT_NEAR;

  localparam coord_t START_X = (SIDE == 1'b0) ? START_X_LEFT : START_X_RIGHT;

  fighter_state_t state_next;
  phase_cnt_t     phase_cnt;
  logic           atk_busy;
  logic [10:0]    pos_step;
  coord_t         posx_next;

  assign atk_busy = (state == ST_ATK_STARTUP) || (state == ST_ATK_ACTIVE) ||
                    (state == ST_ATK_RECOVER);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE, ST_FORWARD, ST_BACKWARD: begin
        if (attack) begin
          state_next = ST_ATK_STARTUP;
        end else if (left && right) begin
          state_next = ST_BACKWARD;
        end else if (left) begin
          state_next = SIDE ? ST_FORWARD : ST_BACKWARD;
        end else if (right) begin
          state_next = SIDE ? ST_BACKWARD : ST_FORWARD;
        end else begin
          state_next = ST_IDLE;
        end
      end
      ST_ATK_STARTUP: begin
        if (phase_cnt == phase_cnt_t'(ATK_STARTUP_CYC - 1)) begin
          state_next = ST_ATK_ACTIVE;
        end
      end
      ST_ATK_ACTIVE: begin
        if (phase_cnt == phase_cnt_t'(ATK_ACTIVE_CYC - 1)) begin
          state_next = ST_ATK_RECOVER;
        end
      end
      ST_ATK_RECOVER: begin
        if (phase_cnt == phase_cnt_t'(ATK_RECOVER_CYC - 1)) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
    // Knockout ends the round for both fighters.
    if (ko) begin
      state_next = ST_IDLE;
    end
  end

  // Phase timer restarts whenever the state changes.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= ST_IDLE;
      phase_cnt <= '0;
    end else begin
      state <= state_next;
      if (atk_busy && (state_next == state)) begin
        phase_cnt <= phase_cnt + 1'b1;
      end else begin
        phase_cnt <= '0;
      end
    end
  end

  // Step from the registered state, one bit wider so the clamp sees the raw sum.
  always_comb begin
    pos_step = {1'b0, posx};
    if (!ko) begin
      case (state)
        ST_FORWARD: begin
          if (SIDE) pos_step = {1'b0, posx} - 11'(STEP_FWD);
          else pos_step = {1'b0, posx} + 11'(STEP_FWD);
        end
        ST_BACKWARD: begin
          if (SIDE) pos_step = {1'b0, posx} + 11'(STEP_BACK);
          else pos_step = {1'b0, posx} - 11'(STEP_BACK);
        end
        default: begin
          pos_step = {1'b0, posx};
        end
      endcase
    end
    if (pos_step < {1'b0, ARENA_MIN_X}) begin
      posx_next = ARENA_MIN_X;
    end else if (pos_step > {1'b0, ARENA_MAX_X}) begin
      posx_next = ARENA_MAX_X;
    end else begin
      posx_next = pos_step[9:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      posx <= START_X;
    end else begin
      posx <= posx_next;
    end
  end

  assign hit_x1 = posx + HIT_X1_OFF;
  assign hit_x2 = posx + HIT_X2_OFF;
  assign hit_y1 = FLOOR_Y + HIT_TOP;
  assign hit_y2 = FLOOR_Y + HIT_BOT;

  assign hurt_x1 = posx + HURT_X1_OFF;
  assign hurt_x2 = posx + HURT_X2_OFF;
  assign hurt_y1 = FLOOR_Y;
  assign hurt_y2 = FLOOR_Y + HURT_HEIGHT;

endmodule

`default_nettype wire

/* rtl/hit_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module hit_detector (
  input  logic                        clk,
  input  logic                        rst,
  input  fighter_pkg::fighter_state_t p1_state,
  input  fighter_pkg::fighter_state_t p2_state,
  input  arena_geom_pkg::coord_t      p1_hit_x1,
  input  arena_geom_pkg::coord_t      p1_hit_x2,
  input  arena_geom_pkg::coord_t      p1_hit_y1,
  input  arena_geom_pkg::coord_t      p1_hit_y2,
  input  arena_geom_pkg::coord_t      p1_hurt_x1,
  input  arena_geom_pkg::coord_t      p1_hurt_x2,
  input  arena_geom_pkg::coord_t      p1_hurt_y1,
  input  arena_geom_pkg::coord_t      p1_hurt_y2,
  input  arena_geom_pkg::coord_t      p2_hit_x1,
  input  arena_geom_pkg::coord_t      p2_hit_x2,
  input  arena_geom_pkg::coord_t      p2_hit_y1,
  input  arena_geom_pkg::coord_t      p2_hit_y2,
  input  arena_geom_pkg::coord_t      p2_hurt_x1,
  input  arena_geom_pkg::coord_t      p2_hurt_x2,
  input  arena_geom_pkg::coord_t      p2_hurt_y1,
  input  arena_geom_pkg::coord_t      p2_hurt_y2,
  output logic                        p1_hit,
  output logic                        p2_hit
);

  import arena_geom_pkg::*;
  import fighter_pkg::*;

  // Inclusive overlap of two axis aligned boxes.
  function automatic logic boxes_overlap(
    input coord_t ax1, input coord_t ax2, input coord_t ay1, input coord_t ay2,
    input coord_t bx1, input coord_t bx2, input coord_t by1, input coord_t by2
  );
    return (ax1 <= bx2) && (bx1 <= ax2) && (ay1 <= by2) && (by1 <= ay2);
  endfunction

  logic p1_active;
  logic p2_active;
  logic p1_contact;
  logic p2_contact;
  logic p1_landed;
  logic p2_landed;
  logic p1_fire;
  logic p2_fire;

  assign p1_active = (p1_state == ST_ATK_ACTIVE);
  assign p2_active = (p2_state == ST_ATK_ACTIVE);

  assign p1_contact = boxes_overlap(p1_hit_x1, p1_hit_x2, p1_hit_y1, p1_hit_y2,
                                    p2_hurt_x1, p2_hurt_x2, p2_hurt_y1, p2_hurt_y2);
  assign p2_contact = boxes_overlap(p2_hit_x1, p2_hit_x2, p2_hit_y1, p2_hit_y2,
                                    p1_hurt_x1, p1_hurt_x2, p1_hurt_y1, p1_hurt_y2);

  // First contact of an active phase only.
  assign p1_fire = p1_active && p1_contact && !p1_landed;
  assign p2_fire = p2_active && p2_contact && !p2_landed;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      p1_hit    <= 1'b0;
      p2_hit    <= 1'b0;
      p1_landed <= 1'b0;
      p2_landed <= 1'b0;
    end else begin
      p1_hit    <= p1_fire;
      p2_hit    <= p2_fire;
      // Latch drops once the attacker leaves its active phase.
      p1_landed <= p1_active && (p1_landed || p1_fire);
      p2_landed <= p2_active && (p2_landed || p2_fire);
    end
  end

endmodule

`default_nettype wire

/* rtl/health_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module health_tracker #(
  parameter int unsigned MAX_HEALTH = fighter_pkg::MAX_HEALTH,
  parameter int unsigned HIT_DAMAGE = fighter_pkg::HIT_DAMAGE
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 p1_hit,
  input  logic                 p2_hit,
  output fighter_pkg::health_t p1_health,
  output fighter_pkg::health_t p2_health,
  output logic                 ko
);

  import fighter_pkg::*;

  localparam health_t DAMAGE = health_t'(HIT_DAMAGE);

  health_t p1_health_next;
  health_t p2_health_next;

  // A hit by one fighter takes health from the other.
  always_comb begin
    p1_health_next = p1_health;
    p2_health_next = p2_health;
    if (p2_hit) begin
      if (p1_health <= DAMAGE) p1_health_next = '0;
      else p1_health_next = p1_health - DAMAGE;
    end
    if (p1_hit) begin
      if (p2_health <= DAMAGE) p2_health_next = '0;
      else p2_health_next = p2_health - DAMAGE;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      p1_health <= health_t'(MAX_HEALTH);
      p2_health <= health_t'(MAX_HEALTH);
      ko        <= 1'b0;
    end else begin
      p1_health <= p1_health_next;
      p2_health <= p2_health_next;
      // Sticky until reset.
      ko <= ko || (p1_health_next == '0) || (p2_health_next == '0);
    end
  end

endmodule

`default_nettype wire

/* rtl/fight_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fight_top #(
  parameter int unsigned MAX_HEALTH = fighter_pkg::MAX_HEALTH,
  parameter int unsigned HIT_DAMAGE = fighter_pkg::HIT_DAMAGE
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        p1_left,
  input  logic                        p1_right,
  input  logic                        p1_attack,
  input  logic                        p2_left,
  input  logic                        p2_right,
  input  logic                        p2_attack,
  output arena_geom_pkg::coord_t      p1_posx,
  output arena_geom_pkg::coord_t      p2_posx,
  output fighter_pkg::fighter_state_t p1_state,
  output fighter_pkg::fighter_state_t p2_state,
  output logic                        p1_hit,
  output logic                        p2_hit,
  output fighter_pkg::health_t        p1_health,
  output fighter_pkg::health_t        p2_health,
  output logic                        ko
);

  import arena_geom_pkg::*;

  coord_t p1_hit_x1, p1_hit_x2, p1_hit_y1, p1_hit_y2;
  coord_t p1_hurt_x1, p1_hurt_x2, p1_hurt_y1, p1_hurt_y2;
  coord_t p2_hit_x1, p2_hit_x2, p2_hit_y1, p2_hit_y2;
  coord_t p2_hurt_x1, p2_hurt_x2, p2_hurt_y1, p2_hurt_y2;

  fighter #(.SIDE(1'b0)) u_p1 (
    .clk(clk), .rst(rst),
    .left(p1_left), .right(p1_right), .attack(p1_attack), .ko(ko),
    .posx(p1_posx), .state(p1_state),
    .hit_x1(p1_hit_x1), .hit_x2(p1_hit_x2), .hit_y1(p1_hit_y1), .hit_y2(p1_hit_y2),
    .hurt_x1(p1_hurt_x1), .hurt_x2(p1_hurt_x2),
    .hurt_y1(p1_hurt_y1), .hurt_y2(p1_hurt_y2)
  );

  fighter #(.SIDE(1'b1)) u_p2 (
    .clk(clk), .rst(rst),
    .left(p2_left), .right(p2_right), .attack(p2_attack), .ko(ko),
    .posx(p2_posx), .state(p2_state),
    .hit_x1(p2_hit_x1), .hit_x2(p2_hit_x2), .hit_y1(p2_hit_y1), .hit_y2(p2_hit_y2),
    .hurt_x1(p2_hurt_x1), .hurt_x2(p2_hurt_x2),
    .hurt_y1(p2_hurt_y1), .hurt_y2(p2_hurt_y2)
  );

  hit_detector u_hits (
    .clk(clk), .rst(rst),
    .p1_state(p1_state), .p2_state(p2_state),
    .p1_hit_x1(p1_hit_x1), .p1_hit_x2(p1_hit_x2),
    .p1_hit_y1(p1_hit_y1), .p1_hit_y2(p1_hit_y2),
    .p1_hurt_x1(p1_hurt_x1), .p1_hurt_x2(p1_hurt_x2),
    .p1_hurt_y1(p1_hurt_y1), .p1_hurt_y2(p1_hurt_y2),
    .p2_hit_x1(p2_hit_x1), .p2_hit_x2(p2_hit_x2),
    .p2_hit_y1(p2_hit_y1), .p2_hit_y2(p2_hit_y2),
    .p2_hurt_x1(p2_hurt_x1), .p2_hurt_x2(p2_hurt_x2),
    .p2_hurt_y1(p2_hurt_y1), .p2_hurt_y2(p2_hurt_y2),
    .p1_hit(p1_hit), .p2_hit(p2_hit)
  );

  health_tracker #(
    .MAX_HEALTH(MAX_HEALTH),
    .HIT_DAMAGE(HIT_DAMAGE)
  ) u_health (
    .clk(clk), .rst(rst),
    .p1_hit(p1_hit), .p2_hit(p2_hit),
    .p1_health(p1_health), .p2_health(p2_health),
    .ko(ko)
  );

endmodule

`default_nettype wire

/* test/fight_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module fight_checker #(
  parameter int unsigned MAX_HEALTH = fighter_pkg::MAX_HEALTH,
  parameter int unsigned HIT_DAMAGE = fighter_pkg::HIT_DAMAGE
) (
  input logic                        clk,
  input logic                        rst,
  input arena_geom_pkg::coord_t      p1_posx,
  input arena_geom_pkg::coord_t      p2_posx,
  input fighter_pkg::fighter_state_t p1_state,
  input fighter_pkg::fighter_state_t p2_state,
  input logic                        p1_hit,
  input logic                        p2_hit,
  input fighter_pkg::health_t        p1_health,
  input fighter_pkg::health_t        p2_health,
  input logic                        ko
);

  import arena_geom_pkg::*;
  import fighter_pkg::*;

  int errors = 0;

  // Expected position one cycle on, from the state the fighter is in now.
  function automatic coord_t moved_posx(input bit side, input fighter_state_t st,
                                        input coord_t x, input logic frozen);
    int s;
    s = int'(x);
    if (!frozen && st == ST_FORWARD) s = side ? s - int'(STEP_FWD) : s + int'(STEP_FWD);
    if (!frozen && st == ST_BACKWARD) s = side ? s + int'(STEP_BACK) : s - int'(STEP_BACK);
    if (s < int'(ARENA_MIN_X)) s = int'(ARENA_MIN_X);
    if (s > int'(ARENA_MAX_X)) s = int'(ARENA_MAX_X);
    return coord_t'(s);
  endfunction

  function automatic health_t after_hit(input health_t h);
    return (int'(h) <= int'(HIT_DAMAGE)) ? '0 : health_t'(int'(h) - int'(HIT_DAMAGE));
  endfunction

  function automatic bit is_attack(input fighter_state_t st);
    return (st == ST_ATK_STARTUP) || (st == ST_ATK_ACTIVE) || (st == ST_ATK_RECOVER);
  endfunction

  function automatic int phase_len(input fighter_state_t st);
    if (st == ST_ATK_STARTUP) return int'(ATK_STARTUP_CYC);
    if (st == ST_ATK_ACTIVE) return int'(ATK_ACTIVE_CYC);
    return int'(ATK_RECOVER_CYC);
  endfunction

  function automatic fighter_state_t phase_after(input fighter_state_t st);
    if (st == ST_ATK_STARTUP) return ST_ATK_ACTIVE;
    if (st == ST_ATK_ACTIVE) return ST_ATK_RECOVER;
    return ST_IDLE;
  endfunction

  // Left fighter faces right, right fighter uses mirrored offsets.
  int  p1_hx1, p1_hx2, p1_ux1, p1_ux2, p2_hx1, p2_hx2, p2_ux1, p2_ux2;
  logic p1_reach, p2_reach, p1_fire_m, p2_fire_m, p1_landed_m, p2_landed_m;
  logic exp_p1_hit, exp_p2_hit, ko_seen;
  coord_t exp_p1_posx, exp_p2_posx;
  health_t exp_p1_health, exp_p2_health;
  fighter_state_t p1_prev, p2_prev;
  int p1_run, p2_run;

  assign p1_hx1 = int'(p1_posx) + int'(HIT_NEAR);
  assign p1_hx2 = int'(p1_posx) + int'(HIT_FAR);
  assign p1_ux1 = int'(p1_posx) + int'(HURT_NEAR);
  assign p1_ux2 = int'(p1_posx) + int'(HURT_FAR);
  assign p2_hx1 = int'(p2_posx) + int'(SPRITE_W) - int'(HIT_FAR);
  assign p2_hx2 = int'(p2_posx) + int'(SPRITE_W) - int'(HIT_NEAR);
  assign p2_ux1 = int'(p2_posx) + int'(SPRITE_W) - int'(HURT_FAR);
  assign p2_ux2 = int'(p2_posx) + int'(SPRITE_W) - int'(HURT_NEAR);

  assign p1_reach = (p1_hx1 <= p2_ux2) && (p2_ux1 <= p1_hx2);
  assign p2_reach = (p2_hx1 <= p1_ux2) && (p1_ux1 <= p2_hx2);
  assign p1_fire_m = (p1_state == ST_ATK_ACTIVE) && p1_reach && !p1_landed_m;
  assign p2_fire_m = (p2_state == ST_ATK_ACTIVE) && p2_reach && !p2_landed_m;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      exp_p1_posx   <= START_X_LEFT;
      exp_p2_posx   <= START_X_RIGHT;
      exp_p1_hit    <= 1'b0;
      exp_p2_hit    <= 1'b0;
      p1_landed_m   <= 1'b0;
      p2_landed_m   <= 1'b0;
      exp_p1_health <= health_t'(MAX_HEALTH);
      exp_p2_health <= health_t'(MAX_HEALTH);
      ko_seen       <= 1'b0;
      p1_prev       <= ST_IDLE;
      p2_prev       <= ST_IDLE;
      p1_run        <= 0;
      p2_run        <= 0;
    end else begin
      exp_p1_posx   <= moved_posx(1'b0, p1_state, p1_posx, ko);
      exp_p2_posx   <= moved_posx(1'b1, p2_state, p2_posx, ko);
      exp_p1_hit    <= p1_fire_m;
      exp_p2_hit    <= p2_fire_m;
      p1_landed_m   <= (p1_state == ST_ATK_ACTIVE) && (p1_landed_m || p1_fire_m);
      p2_landed_m   <= (p2_state == ST_ATK_ACTIVE) && (p2_landed_m || p2_fire_m);
      exp_p1_health <= p2_hit ? after_hit(p1_health) : p1_health;
      exp_p2_health <= p1_hit ? after_hit(p2_health) : p2_health;
      ko_seen       <= ko;
      p1_prev       <= p1_state;
      p2_prev       <= p2_state;
      p1_run        <= (p1_state == p1_prev) ? p1_run + 1 : 1;
      p2_run        <= (p2_state == p2_prev) ? p2_run + 1 : 1;
    end
  end

  a_reset_values: assert property (@(posedge clk) $fell(rst) |->
      p1_posx == START_X_LEFT && p2_posx == START_X_RIGHT &&
      p1_state == ST_IDLE && p2_state == ST_IDLE && !ko && !p1_hit && !p2_hit &&
      p1_health == health_t'(MAX_HEALTH) && p2_health == health_t'(MAX_HEALTH))
    else begin errors++; $error("Outputs after reset are not the reset values."); end

  a_p1_posx: assert property (@(posedge clk) disable iff (rst) p1_posx == exp_p1_posx)
    else begin errors++; $error("Error p1_posx expected %0d actual %0d", exp_p1_posx, p1_posx); end
  a_p2_posx: assert property (@(posedge clk) disable iff (rst) p2_posx == exp_p2_posx)
    else begin errors++; $error("Error p2_posx expected %0d actual %0d", exp_p2_posx, p2_posx); end

  a_in_arena: assert property (@(posedge clk) disable iff (rst)
      p1_posx >= ARENA_MIN_X && p1_posx <= ARENA_MAX_X &&
      p2_posx >= ARENA_MIN_X && p2_posx <= ARENA_MAX_X)
    else begin errors++; $error("A fighter position left the arena."); end

  // Attack phases end after their exact length, into the next phase.
  a_p1_phase_end: assert property (@(posedge clk) disable iff (rst || ko)
      (p1_state != p1_prev && is_attack(p1_prev)) |->
      (p1_run == phase_len(p1_prev) && p1_state == phase_after(p1_prev)))
    else begin errors++; $error("p1 attack phase had the wrong length or order."); end
  a_p2_phase_end: assert property (@(posedge clk) disable iff (rst || ko)
      (p2_state != p2_prev && is_attack(p2_prev)) |->
      (p2_run == phase_len(p2_prev) && p2_state == phase_after(p2_prev)))
    else begin errors++; $error("p2 attack phase had the wrong length or order."); end
  a_phase_bound: assert property (@(posedge clk) disable iff (rst || ko)
      !(p1_state == p1_prev && is_attack(p1_state) && p1_run >= phase_len(p1_state)) &&
      !(p2_state == p2_prev && is_attack(p2_state) && p2_run >= phase_len(p2_state)))
    else begin errors++; $error("An attack phase lasted too long."); end

  a_p1_hit: assert property (@(posedge clk) disable iff (rst) p1_hit == exp_p1_hit)
    else begin errors++; $error("Error p1_hit expected %0d actual %0d", exp_p1_hit, p1_hit); end
  a_p2_hit: assert property (@(posedge clk) disable iff (rst) p2_hit == exp_p2_hit)
    else begin errors++; $error("Error p2_hit expected %0d actual %0d", exp_p2_hit, p2_hit); end

  a_p1_health: assert property (@(posedge clk) disable iff (rst) p1_health == exp_p1_health)
    else begin
      errors++;
      $error("Error p1_health expected %0d actual %0d", exp_p1_health, p1_health);
    end
  a_p2_health: assert property (@(posedge clk) disable iff (rst) p2_health == exp_p2_health)
    else begin
      errors++;
      $error("Error p2_health expected %0d actual %0d", exp_p2_health, p2_health);
    end

  a_ko_level: assert property (@(posedge clk) disable iff (rst)
      ko == (ko_seen || p1_health == '0 || p2_health == '0))
    else begin errors++; $error("ko does not follow the health values."); end
  a_ko_freeze: assert property (@(posedge clk) disable iff (rst)
      ko_seen |-> (p1_state == ST_IDLE && p2_state == ST_IDLE))
    else begin errors++; $error("A fighter left ST_IDLE after knockout."); end

endmodule

bind fight_top fight_checker #(
  .MAX_HEALTH(MAX_HEALTH),
  .HIT_DAMAGE(HIT_DAMAGE)
) u_check (
  .clk(clk), .rst(rst),
  .p1_posx(p1_posx), .p2_posx(p2_posx),
  .p1_state(p1_state), .p2_state(p2_state),
  .p1_hit(p1_hit), .p2_hit(p2_hit),
  .p1_health(p1_health), .p2_health(p2_health),
  .ko(ko)
);

`default_nettype wire

/* test/fight_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fight_tb;

  import arena_geom_pkg::*;
  import fighter_pkg::*;

  // Not a multiple of HIT_DAMAGE, so the last hit saturates at zero.
  localparam int unsigned START_HEALTH = 95;

  logic clk;
  logic rst;
  logic p1_left, p1_right, p1_attack;
  logic p2_left, p2_right, p2_attack;

  coord_t         p1_posx, p2_posx;
  fighter_state_t p1_state, p2_state;
  logic           p1_hit, p2_hit;
  health_t        p1_health, p2_health;
  logic           ko;

  fight_top #(
    .MAX_HEALTH(START_HEALTH),
    .HIT_DAMAGE(fighter_pkg::HIT_DAMAGE)
  ) u_dut (
    .clk(clk), .rst(rst),
    .p1_left(p1_left), .p1_right(p1_right), .p1_attack(p1_attack),
    .p2_left(p2_left), .p2_right(p2_right), .p2_attack(p2_attack),
    .p1_posx(p1_posx), .p2_posx(p2_posx),
    .p1_state(p1_state), .p2_state(p2_state),
    .p1_hit(p1_hit), .p2_hit(p2_hit),
    .p1_health(p1_health), .p2_health(p2_health),
    .ko(ko)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on failure.");
  endtask

  task automatic set_inputs(input logic l1, input logic r1, input logic a1,
                            input logic l2, input logic r2, input logic a2);
    p1_left   = l1;
    p1_right  = r1;
    p1_attack = a1;
    p2_left   = l2;
    p2_right  = r2;
    p2_attack = a2;
  endtask

  // Inputs change and outputs are read 2 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic random_inputs();
    set_inputs(1'($urandom % 2), 1'($urandom % 2), 1'(($urandom % 6) == 0),
               1'($urandom % 2), 1'($urandom % 2), 1'(($urandom % 6) == 0));
  endtask

  task automatic apply_reset();
    set_inputs(0, 0, 0, 0, 0, 0);
    rst = 1'b1;
    repeat (5) next_cycle();
    rst = 1'b0;
  endtask

  // Holds the current inputs until both fighters stand at the given positions.
  task automatic walk_to_positions(input coord_t p1_goal, input coord_t p2_goal);
    int cycles;
    cycles = 0;
    while (p1_posx != p1_goal || p2_posx != p2_goal) begin
      if (cycles >= 200) abort_run("The fighters never reached the arena edges.");
      next_cycle();
      cycles++;
    end
  endtask

  task automatic wait_p1_idle();
    int cycles;
    cycles = 0;
    while (p1_state != ST_IDLE) begin
      if (cycles >= 60) abort_run("p1 did not return to ST_IDLE after an attack.");
      next_cycle();
      cycles++;
    end
  endtask

  task automatic wait_p2_idle();
    int cycles;
    cycles = 0;
    while (p2_state != ST_IDLE) begin
      if (cycles >= 60) abort_run("p2 did not return to ST_IDLE after an attack.");
      next_cycle();
      cycles++;
    end
  endtask

  // Any assertion failure ends the run at once.
  always @(posedge clk) begin
    #1;
    if (u_dut.u_check.errors != 0) abort_run("An assertion in the checker failed.");
  end

  initial begin
    int cycles;
    int attacks;
    set_inputs(0, 0, 0, 0, 0, 0);
    rst = 1'b1;
    void'($urandom(79));
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    repeat (400) begin
      random_inputs();
      next_cycle();
    end

    // Both fighters back off into their own edge and keep pushing.
    apply_reset();
    set_inputs(1, 0, 0, 0, 1, 0);
    walk_to_positions(ARENA_MIN_X, ARENA_MAX_X);
    repeat (3) next_cycle();

    // Then both walk forward across the arena to the far edge.
    set_inputs(0, 1, 0, 1, 0, 0);
    walk_to_positions(ARENA_MAX_X, ARENA_MIN_X);
    repeat (3) next_cycle();

    // Walk both fighters into reach from a fresh start.
    apply_reset();
    set_inputs(0, 1, 0, 1, 0, 0);
    cycles = 0;
    while (int'(p2_posx) - int'(p1_posx) > 40) begin
      if (cycles >= 100) abort_run("The fighters never came within reach.");
      next_cycle();
      cycles++;
    end
    set_inputs(0, 0, 0, 0, 0, 0);
    repeat (3) next_cycle();

    // One counter attack from p2, then p1 attacks until knockout.
    set_inputs(0, 0, 0, 0, 0, 1);
    next_cycle();
    set_inputs(0, 0, 0, 0, 0, 0);
    wait_p2_idle();
    attacks = 0;
    while (!ko) begin
      if (attacks >= 20) abort_run("No knockout after 20 attacks.");
      set_inputs(0, 0, 1, 0, 0, 0);
      next_cycle();
      set_inputs(0, 0, 0, 0, 0, 0);
      wait_p1_idle();
      attacks++;
    end

    // Inputs must have no effect once ko is high.
    repeat (30) begin
      random_inputs();
      next_cycle();
    end

    if (u_dut.u_check.errors == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("The checker reported assertion failures.");
    end
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/arena_geom_pkg.sv
rtl/fighter_pkg.sv
rtl/fighter.sv
rtl/hit_detector.sv
rtl/health_tracker.sv
rtl/fight_top.sv
test/fight_checker.sv
test/fight_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module fight_tb -o fight_sim &&
./obj_dir/fight_sim ||
{ echo "Simulation failed"; exit 1; }
